//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := jtlb_top_tb
FLIST     := jtlb_top.f
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: sim clean

# Build and run; pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/jtlb_hit_compare.sv
// Compare stage: per-way hit check and result-stage registers
`timescale 1ns/100ps
`default_nettype none

module jtlb_hit_compare (
  input  wire                               jtlb_clk,
  input  wire                               cpurst_b,
  input  wire                               ta_vld,
  input  wire  jtlb_pkg::vpn_t              ta_vpn,
  input  wire  jtlb_pkg::pgs_t              ta_pgs,
  input  wire  jtlb_pkg::asid_t             cur_asid,
  input  wire  jtlb_pkg::tag_t              tag0,
  input  wire  jtlb_pkg::tag_t              tag1,
  input  wire  jtlb_pkg::data_t             data0,
  input  wire  jtlb_pkg::data_t             data1,
  output logic                              tc_vld,
  output logic [jtlb_pkg::num_ways-1:0]     tc_way_hit,
  output jtlb_pkg::vpn_t                    tc_vpn,
  output jtlb_pkg::pgs_t                    tc_pgs,
  output jtlb_pkg::data_t                   tc_data0,
  output jtlb_pkg::data_t                   tc_data1
);

  import jtlb_pkg::*;

  vpn_t                vpn_masked;
  logic [num_ways-1:0] way_hit;

  // One way's match against the request
  function automatic logic tag_match(tag_t tag, vpn_t vpn_m, pgs_t pgs, asid_t asid);
    logic asid_ok;
    // Global entries ignore the ASID
    asid_ok = (tag.asid == asid) || tag.g;
    return tag.vld && (tag.vpn == vpn_m) && (tag.pgs == pgs) && asid_ok;
  endfunction

  // ================================================
  // Hit check
  // ================================================
  assign vpn_masked = vpn_mask(ta_vpn, ta_pgs);

  assign way_hit[0] = tag_match(tag0, vpn_masked, ta_pgs, cur_asid);
  assign way_hit[1] = tag_match(tag1, vpn_masked, ta_pgs, cur_asid);

  // ================================================
  // Result-stage registers
  // ================================================
  always_ff @(posedge jtlb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tc_vld <= 1'b0;
    else
      tc_vld <= ta_vld;
  end

  always_ff @(posedge jtlb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tc_way_hit <= '0;
    else if (ta_vld)
      tc_way_hit <= way_hit;
  end

  // Request and both data words, held for the result stage
  always_ff @(posedge jtlb_clk)
  begin
    if (ta_vld)
    begin
      tc_vpn   <= ta_vpn;
      tc_pgs   <= ta_pgs;
      tc_data0 <= data0;
      tc_data1 <= data1;
    end
  end

endmodule

`default_nettype wire

//--- hw/jtlb_pkg.sv
// Joint TLB widths, entry types, page-size encodings and VPN masking
`default_nettype none

package jtlb_pkg;

  // ================================================
  // Widths
  // ================================================
  localparam int vpn_w     = 27;
  localparam int ppn_w     = 28;
  localparam int asid_w    = 16;
  localparam int flg_w     = 16;
  localparam int pgs_w     = 3;
  localparam int vpn_lvl_w = 9;
  localparam int set_idx_w = 6;
  localparam int num_ways  = 2;

  // One-hot page size
  localparam logic [pgs_w-1:0] pgs_4k = 3'b001;
  localparam logic [pgs_w-1:0] pgs_2m = 3'b010;
  localparam logic [pgs_w-1:0] pgs_1g = 3'b100;

  typedef logic [vpn_w-1:0]     vpn_t;
  typedef logic [ppn_w-1:0]     ppn_t;
  typedef logic [asid_w-1:0]    asid_t;
  typedef logic [pgs_w-1:0]     pgs_t;
  typedef logic [set_idx_w-1:0] set_idx_t;

  // ================================================
  // Entry formats
  // ================================================
  // Tag entry, 48 bits
  typedef struct packed {
    logic  vld;
    vpn_t  vpn;
    asid_t asid;
    pgs_t  pgs;
    logic  g;
  } tag_t;

  // Data entry, 44 bits
  typedef struct packed {
    ppn_t             ppn;
    logic [flg_w-1:0] flg;
  } data_t;

  // Clear the VPN levels below the page size
  function automatic vpn_t vpn_mask(vpn_t vpn, pgs_t pgs);
    vpn_t vpn_2m;
    vpn_t vpn_1g;
    vpn_2m = {vpn[vpn_w-1:vpn_lvl_w], {vpn_lvl_w{1'b0}}};
    vpn_1g = {vpn[vpn_w-1:2*vpn_lvl_w], {2*vpn_lvl_w{1'b0}}};
    return ({vpn_w{|(pgs & pgs_4k)}} & vpn)
         | ({vpn_w{|(pgs & pgs_2m)}} & vpn_2m)
         | ({vpn_w{|(pgs & pgs_1g)}} & vpn_1g);
  endfunction

endpackage

`default_nettype wire

//--- hw/jtlb_req_decode.sv
// Request stage: set index, memory enables, write payloads, compare-stage controls
`timescale 1ns/100ps
`default_nettype none

module jtlb_req_decode (
  input  wire                               jtlb_clk,
  input  wire                               cpurst_b,
  input  wire                               req,
  input  wire                               req_write,
  input  wire  jtlb_pkg::vpn_t              req_vpn,
  input  wire  jtlb_pkg::pgs_t              req_pgs,
  input  wire  [jtlb_pkg::num_ways-1:0]     req_way_sel,
  input  wire                               wr_vld,
  input  wire  jtlb_pkg::asid_t             wr_asid,
  input  wire                               wr_g,
  input  wire  jtlb_pkg::ppn_t              wr_ppn,
  input  wire  [jtlb_pkg::flg_w-1:0]        wr_flg,
  output jtlb_pkg::set_idx_t                mem_idx,
  output logic                              tag_cen,
  output logic                              data_cen,
  output logic [jtlb_pkg::num_ways-1:0]     mem_wen,
  output jtlb_pkg::tag_t                    tag_din,
  output jtlb_pkg::data_t                   data_din,
  output logic                              ta_vld,
  output jtlb_pkg::vpn_t                    ta_vpn,
  output jtlb_pkg::pgs_t                    ta_pgs
);

  import jtlb_pkg::*;

  vpn_t vpn_masked;
  vpn_t vpn_shift;
  logic lookup;

  assign lookup = req && !req_write;

  // ================================================
  // Set index
  // ================================================
  // Page number at the request's own level, low bits pick the set
  assign vpn_shift = ({vpn_w{|(req_pgs & pgs_4k)}} & req_vpn)
                   | ({vpn_w{|(req_pgs & pgs_2m)}}
                      & {{vpn_lvl_w{1'b0}}, req_vpn[vpn_w-1:vpn_lvl_w]})
                   | ({vpn_w{|(req_pgs & pgs_1g)}}
                      & {{2*vpn_lvl_w{1'b0}}, req_vpn[vpn_w-1:2*vpn_lvl_w]});
  assign mem_idx = vpn_shift[set_idx_w-1:0];

  // ================================================
  // Memory enables
  // ================================================
  assign tag_cen  = req;
  assign mem_wen  = {num_ways{req && req_write}} & req_way_sel;
  assign data_cen = lookup || (req && (|req_way_sel));

  // Write payloads, stored VPN is kept masked
  assign vpn_masked = vpn_mask(req_vpn, req_pgs);
  assign tag_din    = '{vld: wr_vld, vpn: vpn_masked, asid: wr_asid, pgs: req_pgs, g: wr_g};
  assign data_din   = '{ppn: wr_ppn, flg: wr_flg};

  // ================================================
  // Compare-stage controls
  // ================================================
  always_ff @(posedge jtlb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ta_vld <= 1'b0;
    else
      ta_vld <= lookup;
  end

  always_ff @(posedge jtlb_clk)
  begin
    if (lookup)
    begin
      ta_vpn <= req_vpn;
      ta_pgs <= req_pgs;
    end
  end

endmodule

`default_nettype wire

//--- hw/jtlb_result.sv
// Result stage: hit, miss and multi-hit judgement, PPN and flag select, walk request
`timescale 1ns/100ps
`default_nettype none

module jtlb_result (
  input  wire                               tc_vld,
  input  wire  [jtlb_pkg::num_ways-1:0]     tc_way_hit,
  input  wire  jtlb_pkg::vpn_t              tc_vpn,
  input  wire  jtlb_pkg::pgs_t              tc_pgs,
  input  wire  jtlb_pkg::data_t             tc_data0,
  input  wire  jtlb_pkg::data_t             tc_data1,
  input  wire                               ptw_en,
  output logic                              res_vld,
  output logic                              res_hit,
  output logic                              res_miss,
  output logic                              res_hit_mult,
  output logic                              res_way,
  output jtlb_pkg::ppn_t                    res_ppn,
  output logic [jtlb_pkg::flg_w-1:0]        res_flg,
  output logic                              ptw_req,
  output jtlb_pkg::vpn_t                    ptw_vpn
);

  import jtlb_pkg::*;

  logic any_hit;
  logic last_probe;

  // ================================================
  // Hit / miss judgement
  // ================================================
  assign any_hit      = |tc_way_hit;
  assign res_vld      = tc_vld;
  assign res_hit      = tc_vld && (tc_way_hit[0] ^ tc_way_hit[1]);
  assign res_hit_mult = tc_vld && (&tc_way_hit);
  assign res_miss     = tc_vld && !any_hit;
  assign res_way      = tc_way_hit[1];

  // ================================================
  // PPN and flags
  // ================================================
  // AND-OR of the hitting ways
  assign res_ppn = ({ppn_w{tc_way_hit[0]}} & tc_data0.ppn)
                 | ({ppn_w{tc_way_hit[1]}} & tc_data1.ppn);
  assign res_flg = ({flg_w{tc_way_hit[0]}} & tc_data0.flg)
                 | ({flg_w{tc_way_hit[1]}} & tc_data1.flg);

  // ================================================
  // Walk request
  // ================================================
  // 1G is the last probe size
  assign last_probe = |(tc_pgs & pgs_1g);
  assign ptw_req    = res_miss && last_probe && ptw_en;
  assign ptw_vpn    = tc_vpn;

endmodule

`default_nettype wire

//--- hw/jtlb_top.sv
// Joint TLB lookup pipeline top: request stage, tag and data memories, compare, result
`timescale 1ns/100ps
`default_nettype none

module jtlb_top (
  input  wire                               jtlb_clk,
  input  wire                               cpurst_b,
  input  wire                               req,
  input  wire                               req_write,
  input  wire  jtlb_pkg::vpn_t              req_vpn,
  input  wire  jtlb_pkg::pgs_t              req_pgs,
  input  wire  [jtlb_pkg::num_ways-1:0]     req_way_sel,
  input  wire                               wr_vld,
  input  wire  jtlb_pkg::asid_t             wr_asid,
  input  wire                               wr_g,
  input  wire  jtlb_pkg::ppn_t              wr_ppn,
  input  wire  [jtlb_pkg::flg_w-1:0]        wr_flg,
  input  wire  jtlb_pkg::asid_t             cur_asid,
  input  wire                               ptw_en,
  output logic                              res_vld,
  output logic                              res_hit,
  output logic                              res_miss,
  output logic                              res_hit_mult,
  output logic                              res_way,
  output jtlb_pkg::ppn_t                    res_ppn,
  output logic [jtlb_pkg::flg_w-1:0]        res_flg,
  output logic                              ptw_req,
  output jtlb_pkg::vpn_t                    ptw_vpn
);

  import jtlb_pkg::*;

  set_idx_t            mem_idx;
  logic                tag_cen;
  logic                data_cen;
  logic [num_ways-1:0] mem_wen;
  tag_t                tag_din;
  data_t               data_din;
  tag_t                tag_dout0;
  tag_t                tag_dout1;
  data_t               data_dout0;
  data_t               data_dout1;
  logic                ta_vld;
  vpn_t                ta_vpn;
  pgs_t                ta_pgs;
  logic                tc_vld;
  logic [num_ways-1:0] tc_way_hit;
  vpn_t                tc_vpn;
  pgs_t                tc_pgs;
  data_t               tc_data0;
  data_t               tc_data1;

  // ================================================
  // Request stage and memories
  // ================================================
  jtlb_req_decode u_req_decode (
    .jtlb_clk (jtlb_clk), .cpurst_b (cpurst_b), .req (req), .req_write (req_write),
    .req_vpn (req_vpn), .req_pgs (req_pgs), .req_way_sel (req_way_sel),
    .wr_vld (wr_vld), .wr_asid (wr_asid), .wr_g (wr_g), .wr_ppn (wr_ppn), .wr_flg (wr_flg),
    .mem_idx (mem_idx), .tag_cen (tag_cen), .data_cen (data_cen), .mem_wen (mem_wen),
    .tag_din (tag_din), .data_din (data_din),
    .ta_vld (ta_vld), .ta_vpn (ta_vpn), .ta_pgs (ta_pgs)
  );

  jtlb_way_ram #(.payload_t (tag_t)) u_tag_ram (
    .jtlb_clk (jtlb_clk), .cen (tag_cen), .wen (mem_wen), .idx (mem_idx),
    .din (tag_din), .dout0 (tag_dout0), .dout1 (tag_dout1)
  );

  jtlb_way_ram #(.payload_t (data_t)) u_data_ram (
    .jtlb_clk (jtlb_clk), .cen (data_cen), .wen (mem_wen), .idx (mem_idx),
    .din (data_din), .dout0 (data_dout0), .dout1 (data_dout1)
  );

  // ================================================
  // Compare and result stages
  // ================================================
  jtlb_hit_compare u_hit_compare (
    .jtlb_clk (jtlb_clk), .cpurst_b (cpurst_b), .ta_vld (ta_vld), .ta_vpn (ta_vpn),
    .ta_pgs (ta_pgs), .cur_asid (cur_asid), .tag0 (tag_dout0), .tag1 (tag_dout1),
    .data0 (data_dout0), .data1 (data_dout1), .tc_vld (tc_vld), .tc_way_hit (tc_way_hit),
    .tc_vpn (tc_vpn), .tc_pgs (tc_pgs), .tc_data0 (tc_data0), .tc_data1 (tc_data1)
  );

  jtlb_result u_result (
    .tc_vld (tc_vld), .tc_way_hit (tc_way_hit), .tc_vpn (tc_vpn), .tc_pgs (tc_pgs),
    .tc_data0 (tc_data0), .tc_data1 (tc_data1), .ptw_en (ptw_en),
    .res_vld (res_vld), .res_hit (res_hit), .res_miss (res_miss),
    .res_hit_mult (res_hit_mult), .res_way (res_way), .res_ppn (res_ppn),
    .res_flg (res_flg), .ptw_req (ptw_req), .ptw_vpn (ptw_vpn)
  );

endmodule

`default_nettype wire

//--- hw/jtlb_way_ram.sv
// Two-way set memory, single port, synchronous read, payload set by type parameter
`timescale 1ns/100ps
`default_nettype none

module jtlb_way_ram #(
  parameter type payload_t = jtlb_pkg::tag_t
) (
  input  wire                               jtlb_clk,
  input  wire                               cen,
  input  wire  [jtlb_pkg::num_ways-1:0]     wen,
  input  wire  jtlb_pkg::set_idx_t          idx,
  input  wire  payload_t                    din,
  output payload_t                          dout0,
  output payload_t                          dout1
);

  import jtlb_pkg::*;

  localparam int num_sets = 1 << set_idx_w;

  // 64 sets of two ways
  payload_t mem [0:num_sets-1][0:num_ways-1];

  // ================================================
  // Write port
  // ================================================
  always_ff @(posedge jtlb_clk)
  begin
    if (cen)
    begin
      for (int w = 0; w < num_ways; w++)
      begin
        if (wen[w])
          mem[idx][w] <= din;
      end
    end
  end

  // ================================================
  // Read port
  // ================================================
  // Both ways come out one cycle after the index
  always_ff @(posedge jtlb_clk)
  begin
    if (cen)
    begin
      dout0 <= mem[idx][0];
      dout1 <= mem[idx][1];
    end
  end

endmodule

`default_nettype wire

//--- jtlb_top.f
hw/jtlb_pkg.sv
hw/jtlb_way_ram.sv
hw/jtlb_req_decode.sv
hw/jtlb_hit_compare.sv
hw/jtlb_result.sv
hw/jtlb_top.sv
tests/jtlb_top_checker.sv
tests/jtlb_top_tb.sv

//--- tests/jtlb_top_checker.sv
// Concurrent protocol assertions for the joint TLB pipeline and their bind to the top level
`timescale 1ns/100ps
`default_nettype none

module jtlb_top_checker (
  input wire jtlb_clk,
  input wire cpurst_b,
  input wire req,
  input wire req_write,
  input wire res_vld,
  input wire res_hit,
  input wire res_miss,
  input wire res_hit_mult,
  input wire ptw_req
);

  // ================================================
  // Reset and result rules
  // ================================================
  a_reset_low: assert property (@(posedge jtlb_clk)
    !cpurst_b |-> !res_vld && !res_hit && !res_miss && !res_hit_mult && !ptw_req)
    else $error("result outputs active during reset");

  a_hit_xor_miss: assert property (@(posedge jtlb_clk) disable iff (!cpurst_b)
    !(res_hit && res_miss))
    else $error("hit and miss together");

  a_walk_on_miss: assert property (@(posedge jtlb_clk) disable iff (!cpurst_b)
    ptw_req |-> res_miss)
    else $error("walk request without a miss");

  // Lookup latency is two cycles
  a_latency: assert property (@(posedge jtlb_clk) disable iff (!cpurst_b)
    (req && !req_write) |-> ##2 res_vld)
    else $error("no result two cycles after a lookup");

  a_vld_source: assert property (@(posedge jtlb_clk) disable iff (!cpurst_b)
    res_vld |-> $past(req && !req_write, 2))
    else $error("result without a lookup two cycles before");

endmodule

bind jtlb_top jtlb_top_checker u_checker (
  .jtlb_clk (jtlb_clk), .cpurst_b (cpurst_b), .req (req), .req_write (req_write),
  .res_vld (res_vld), .res_hit (res_hit), .res_miss (res_miss),
  .res_hit_mult (res_hit_mult), .ptw_req (ptw_req)
);

`default_nettype wire

//--- tests/jtlb_top_tb.sv
// Joint TLB testbench with clock, reset, stimulus, entry model, immediate checks and report
`timescale 1ns/100ps
`default_nettype none

module jtlb_top_tb;

  import jtlb_pkg::*;

  typedef struct packed {
    logic             vld;
    logic             hit;
    logic             miss;
    logic             mult;
    logic             way;
    ppn_t             ppn;
    logic [flg_w-1:0] flg;
    logic             ptw;
    vpn_t             pvpn;
  } exp_t;

  logic jtlb_clk, cpurst_b, req, req_write, wr_vld, wr_g, ptw_en;
  vpn_t req_vpn;
  pgs_t req_pgs;
  logic [num_ways-1:0] req_way_sel;
  asid_t wr_asid, cur_asid;
  ppn_t wr_ppn;
  logic [flg_w-1:0] wr_flg;
  logic res_vld, res_hit, res_miss, res_hit_mult, res_way, ptw_req;
  ppn_t res_ppn;
  logic [flg_w-1:0] res_flg;
  vpn_t ptw_vpn;

  // Entry model of 64 sets by two ways
  logic             m_vld  [64][2];
  vpn_t             m_vpn  [64][2];
  asid_t            m_asid [64][2];
  pgs_t             m_pgs  [64][2];
  logic             m_g    [64][2];
  ppn_t             m_ppn  [64][2];
  logic [flg_w-1:0] m_flg  [64][2];

  exp_t        exp_q[$];
  logic [31:0] rng = 32'ha85d8a03;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  logic        seen_vld;
  vpn_t        st_vpn [12];
  pgs_t        st_pgs [12];

  jtlb_top u_jtlb_top (.*);

  initial
  begin
    jtlb_clk = 1'b0;
    forever #4 jtlb_clk = ~jtlb_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // ================================================
  // Reference model
  // ================================================
  function automatic set_idx_t set_of(vpn_t vpn, pgs_t pgs);
    if (pgs == pgs_2m)
      return vpn[14:9];
    else if (pgs == pgs_1g)
      return vpn[23:18];
    return vpn[5:0];
  endfunction

  function automatic vpn_t page_of(vpn_t vpn, pgs_t pgs);
    if (pgs == pgs_2m)
      return {vpn[26:9], 9'd0};
    else if (pgs == pgs_1g)
      return {vpn[26:18], 18'd0};
    return vpn;
  endfunction

  function automatic exp_t predict(vpn_t vpn, pgs_t pgs);
    exp_t     e;
    set_idx_t s;
    logic [1:0] h;
    s = set_of(vpn, pgs);
    for (int w = 0; w < 2; w++)
      h[w] = m_vld[s][w] && (m_vpn[s][w] == page_of(vpn, pgs)) && (m_pgs[s][w] == pgs)
             && ((m_asid[s][w] == cur_asid) || m_g[s][w]);
    e      = '0;
    e.vld  = 1'b1;
    e.hit  = (h == 2'b01) || (h == 2'b10);
    e.mult = (h == 2'b11);
    e.miss = (h == 2'b00);
    e.way  = h[1];
    e.ppn  = ({ppn_w{h[0]}} & m_ppn[s][0]) | ({ppn_w{h[1]}} & m_ppn[s][1]);
    e.flg  = ({flg_w{h[0]}} & m_flg[s][0]) | ({flg_w{h[1]}} & m_flg[s][1]);
    e.ptw  = e.miss && (pgs == pgs_1g) && ptw_en;
    e.pvpn = vpn;
    return e;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input exp_t e);
    if (res_vld)
      seen_vld = 1'b1;
    compare_value("res_vld", 32'(res_vld), 32'(e.vld));
    compare_value("ptw_req", 32'(ptw_req), 32'(e.ptw));
    if (e.vld)
    begin
      compare_value("res_hit", 32'(res_hit), 32'(e.hit));
      compare_value("res_miss", 32'(res_miss), 32'(e.miss));
      compare_value("res_hit_mult", 32'(res_hit_mult), 32'(e.mult));
      compare_value("res_way", 32'(res_way), 32'(e.way));
      compare_value("res_ppn", 32'(res_ppn), 32'(e.ppn));
      compare_value("res_flg", 32'(res_flg), 32'(e.flg));
      if (e.ptw)
        compare_value("ptw_vpn", 32'(ptw_vpn), 32'(e.pvpn));
    end
  endtask

  // ================================================
  // Stimulus
  // ================================================
  // One request slot; the result from two slots back is checked first
  task automatic issue(input logic r, input logic w, input vpn_t vpn, input pgs_t pgs,
                       input logic [1:0] way, input logic v, input asid_t a, input logic g,
                       input ppn_t p, input logic [flg_w-1:0] f);
    exp_t     e;
    set_idx_t s;
    @(negedge jtlb_clk);
    if (exp_q.size() == 2)
      check_result(exp_q.pop_front());
    req = r;
    req_write = w;
    req_vpn = vpn;
    req_pgs = pgs;
    req_way_sel = way;
    wr_vld = v;
    wr_asid = a;
    wr_g = g;
    wr_ppn = p;
    wr_flg = f;
    e = '0;
    if (r && !w)
      e = predict(vpn, pgs);
    if (r && w)
    begin
      s = set_of(vpn, pgs);
      for (int i = 0; i < 2; i++)
      begin
        if (way[i])
        begin
          m_vld[s][i]  = v;
          m_vpn[s][i]  = page_of(vpn, pgs);
          m_asid[s][i] = a;
          m_pgs[s][i]  = pgs;
          m_g[s][i]    = g;
          m_ppn[s][i]  = p;
          m_flg[s][i]  = f;
        end
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic write_entry(input logic [1:0] way, input vpn_t vpn, input pgs_t pgs,
                             input logic v, input asid_t a, input logic g, input ppn_t p,
                             input logic [flg_w-1:0] f);
    issue(1'b1, 1'b1, vpn, pgs, way, v, a, g, p, f);
  endtask

  task automatic lookup_vpn(input vpn_t vpn, input pgs_t pgs);
    issue(1'b1, 1'b0, vpn, pgs, 2'b00, 1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic idle();
    issue(1'b0, 1'b0, '0, pgs_4k, 2'b00, 1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic wait_result();
    int cnt;
    cnt = 0;
    seen_vld = 1'b0;
    while (!seen_vld)
    begin
      if (cnt >= 8)
      begin
        timeouts++;
        $display("Timeout: no lookup result within 8 cycles at t=%0t", $time);
        break;
      end
      idle();
      cnt++;
    end
  endtask

  initial
  begin
    int   k;
    vpn_t v;
    {req, req_write, req_vpn, req_pgs, req_way_sel} = '0;
    {wr_vld, wr_asid, wr_g, wr_ppn, wr_flg} = '0;
    cur_asid = 16'h0011;
    ptw_en = 1'b0;
    cpurst_b = 1'b0;
    repeat (2) @(negedge jtlb_clk);
    cpurst_b = 1'b1;
    // Clear both ways of every set
    for (int i = 0; i < 64; i++)
      write_entry(2'b11, vpn_t'(i), pgs_4k, 1'b0, '0, 1'b0, ppn_t'(32'h0a5c0000 | i),
                  16'(i * 3));
    repeat (3) idle();

    // 4K hit in way 0
    write_entry(2'b01, 27'h12_3456, pgs_4k, 1'b1, 16'h0011, 1'b0, 28'h0ab_cdef, 16'h00c7);
    lookup_vpn(27'h12_3456, pgs_4k);
    wait_result();

    // 2M entry in set 0 hits for any low 9 bits and misses as a 4K probe of set 0
    write_entry(2'b10, 27'h2a_0000, pgs_2m, 1'b1, 16'h0011, 1'b0, 28'h123_4567, 16'h0f0f);
    lookup_vpn(27'h2a_01ff, pgs_2m);
    wait_result();
    lookup_vpn(27'h2a_00a5, pgs_2m);
    wait_result();
    lookup_vpn(27'h2a_0000, pgs_4k);
    wait_result();

    // ASID mismatch, global override, invalid entry
    write_entry(2'b01, 27'h01_0203, pgs_4k, 1'b1, 16'h0022, 1'b0, 28'h000_1111, 16'h0001);
    lookup_vpn(27'h01_0203, pgs_4k);
    wait_result();
    write_entry(2'b10, 27'h01_0204, pgs_4k, 1'b1, 16'h0022, 1'b1, 28'h000_2222, 16'h0002);
    lookup_vpn(27'h01_0204, pgs_4k);
    wait_result();
    write_entry(2'b01, 27'h01_0205, pgs_4k, 1'b0, 16'h0011, 1'b0, 28'h000_3333, 16'h0003);
    lookup_vpn(27'h01_0205, pgs_4k);
    wait_result();

    // Same entry in both ways
    write_entry(2'b01, 27'h05_5507, pgs_4k, 1'b1, 16'h0011, 1'b0, 28'h777_0000, 16'h0070);
    write_entry(2'b10, 27'h05_5507, pgs_4k, 1'b1, 16'h0011, 1'b0, 28'h777_0000, 16'h0070);
    lookup_vpn(27'h05_5507, pgs_4k);
    wait_result();

    // Walk requests
    ptw_en = 1'b1;
    lookup_vpn(27'h7f_c123, pgs_1g);
    wait_result();
    ptw_en = 1'b0;
    lookup_vpn(27'h7f_c123, pgs_1g);
    wait_result();
    ptw_en = 1'b1;
    lookup_vpn(27'h7f_c12a, pgs_4k);
    wait_result();

    // ================================================
    // Random back-to-back lookups
    // ================================================
    for (int i = 0; i < 12; i++)
    begin
      k = rand32() % 3;
      st_pgs[i] = (k == 0) ? pgs_4k : (k == 1) ? pgs_2m : pgs_1g;
      st_vpn[i] = vpn_t'(rand32());
      write_entry(2'(1 + (rand32() % 2)), st_vpn[i], st_pgs[i], 1'b1,
                  rand32() % 2 == 0 ? 16'h0011 : 16'h0022, 1'b0, ppn_t'(rand32()),
                  16'(rand32()));
    end
    for (int i = 0; i < 48; i++)
    begin
      k = rand32() % 12;
      v = vpn_t'(rand32());
      if (rand32() % 2 == 0)
        lookup_vpn(page_of(st_vpn[k], st_pgs[k]) | (v & ~page_of(27'h7ff_ffff, st_pgs[k])),
                   st_pgs[k]);
      else
        lookup_vpn(v, (k % 3 == 0) ? pgs_4k : (k % 3 == 1) ? pgs_2m : pgs_1g);
    end
    repeat (3) idle();

    $display("Checks: %0d  mismatches: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
